//--- logic/ilk_rx_pkg.sv
package ilk_rx_pkg;

   localparam int WORDS      = 4;   // 64-bit words per segment
   localparam int LOG_WORDS  = 3;   // width of the word count field
   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
   localparam int CNT_W      = 16;

   typedef logic [WORDS*64-1:0]   seg_data_t;
   typedef logic [LOG_WORDS-1:0]  num_valid_t;
   typedef logic [3:0]            eopbits_t;    // interlaken eop code
   typedef logic [4:0]            empty_t;      // unused bytes in the last beat
   typedef logic [CNT_W-1:0]      cnt_t;
   typedef logic [7:0]            apb_addr_t;
   typedef logic [31:0]           apb_data_t;
   typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;

   // status register map
   localparam apb_addr_t REG_PKT   = 8'h00;
   localparam apb_addr_t REG_ERR   = 8'h04;
   localparam apb_addr_t REG_DROP  = 8'h08;
   localparam apb_addr_t REG_FRAME = 8'h0C;
   localparam apb_addr_t REG_CTRL  = 8'h10;  // bit 0 clears all counters

   // beat buffer occupancy
   typedef enum logic [1:0] {
      EMPTY,
      PARTIAL,
      FULL
   } fifo_state_t;

endpackage

//--- logic/avl_beat_if.sv
`timescale 1ns/1ps

// one decoded avalon-st beat, no ready since the interlaken side never stalls
interface avl_beat_if;

   import ilk_rx_pkg::*;

   seg_data_t data;
   logic      sop;
   logic      eop;
   empty_t    empty;
   logic      error;
   logic      valid;

   modport source (
      output data, sop, eop, empty, error, valid
   );

   modport sink (
      input  data, sop, eop, empty, error, valid
   );

endinterface

//--- logic/ilk_to_avalon_adapter.sv
`timescale 1ns/1ps

module ilk_to_avalon_adapter (
   input  logic                   ilk_valid,
   input  ilk_rx_pkg::seg_data_t  ilk_data,
   input  ilk_rx_pkg::num_valid_t ilk_num_valid,  // words carried this cycle
   input  logic                   ilk_sop,
   input  ilk_rx_pkg::eopbits_t   ilk_eopbits,    // eop, empty and error packed here
   avl_beat_if.source             beat
);

   import ilk_rx_pkg::*;

   logic       seg_ok;
   num_valid_t word_gap;    // idle words at the end of the segment
   empty_t     base_empty;
   logic [5:0] empty_wide;  // spare bit so an overflow shows up

   assign seg_ok     = ilk_valid && (ilk_num_valid != '0)
                       && (ilk_num_valid <= num_valid_t'(WORDS));
   assign word_gap   = num_valid_t'(WORDS) - ilk_num_valid;
   assign base_empty = empty_t'({word_gap, 3'b000});  // 8 bytes per idle word

   always_comb begin
      beat.valid = 1'b0;
      beat.data  = '0;
      beat.sop   = 1'b0;
      beat.eop   = 1'b0;
      beat.error = 1'b0;
      empty_wide = '0;

      if (seg_ok) begin
         beat.valid = 1'b1;
         beat.data  = ilk_data;
         beat.sop   = ilk_sop;

         if (ilk_eopbits == 4'b0000) begin
            empty_wide = {1'b0, base_empty};  // mid-packet segment
         end else if (ilk_eopbits == 4'b1000) begin
            beat.eop   = 1'b1;
            empty_wide = {1'b0, base_empty};  // last word fully used
         end else if (ilk_eopbits[3]) begin
            // k valid bytes in the last word
            beat.eop   = 1'b1;
            empty_wide = {1'b0, base_empty} + 6'd8 - {3'b000, ilk_eopbits[2:0]};
         end else begin
            beat.eop   = 1'b1;  // 0001 and the unused codes
            beat.error = 1'b1;
         end
      end

      beat.empty = empty_wide[4:0];
   end

   // the computed byte count must fit the avalon empty field
   always_comb begin
      if (beat.valid) begin
         assert final (empty_wide <= 6'd31)
            else $error("adapter empty out of range: %0d", empty_wide);
         assert final (!beat.error || beat.eop)
            else $error("adapter error flagged without eop");
      end
   end

endmodule

//--- logic/avl_out_fifo.sv
`timescale 1ns/1ps

module avl_out_fifo (
   input  logic                  clk,
   input  logic                  rst_n,
   avl_beat_if.sink              beat,
   output ilk_rx_pkg::seg_data_t avl_data,
   output logic                  avl_sop,
   output logic                  avl_eop,
   output logic                  avl_error,
   output ilk_rx_pkg::empty_t    avl_empty,
   output logic                  avl_valid,
   input  logic                  avl_ready,
   output logic                  drop
);

   import ilk_rx_pkg::*;

   seg_data_t   data_mem  [FIFO_DEPTH];
   logic        sop_mem   [FIFO_DEPTH];
   logic        eop_mem   [FIFO_DEPTH];
   logic        error_mem [FIFO_DEPTH];
   empty_t      empty_mem [FIFO_DEPTH];

   fifo_ptr_t   wr_ptr;
   fifo_ptr_t   rd_ptr;
   fifo_ptr_t   wr_ptr_nxt;
   fifo_ptr_t   rd_ptr_nxt;
   fifo_state_t state;
   logic        push;
   logic        pop;

   assign pop  = avl_valid && avl_ready;
   assign push = beat.valid && ((state != FULL) || pop);  // same-cycle pop frees a slot

   assign wr_ptr_nxt = (wr_ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
   assign rd_ptr_nxt = (rd_ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state  <= EMPTY;
         wr_ptr <= '0;
         rd_ptr <= '0;
         drop   <= 1'b0;
      end else begin
         drop <= beat.valid && !push;  // beat arrived with no room
         if (push) begin
            wr_ptr <= wr_ptr_nxt;
         end
         if (pop) begin
            rd_ptr <= rd_ptr_nxt;
         end
         case ({push, pop})
            2'b10:   state <= (wr_ptr_nxt == rd_ptr) ? FULL : PARTIAL;
            2'b01:   state <= (rd_ptr_nxt == wr_ptr) ? EMPTY : PARTIAL;
            default: state <= state;  // idle, or push and pop together
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         data_mem[wr_ptr]  <= beat.data;
         sop_mem[wr_ptr]   <= beat.sop;
         eop_mem[wr_ptr]   <= beat.eop;
         error_mem[wr_ptr] <= beat.error;
         empty_mem[wr_ptr] <= beat.empty;
      end
   end

   // head of the queue drives the avalon side
   assign avl_valid = (state != EMPTY);
   assign avl_data  = data_mem[rd_ptr];
   assign avl_sop   = sop_mem[rd_ptr];
   assign avl_eop   = eop_mem[rd_ptr];
   assign avl_error = error_mem[rd_ptr];
   assign avl_empty = empty_mem[rd_ptr];

   // equal pointers only when empty or full, so occupancy stays within FIFO_DEPTH
   assert property (@(posedge clk) disable iff (!rst_n)
      (wr_ptr == rd_ptr) == (state != PARTIAL));

   // a stalled beat holds until the sink takes it
   assert property (@(posedge clk) disable iff (!rst_n)
      (avl_valid && !avl_ready) |=> avl_valid && $stable(avl_data) && $stable(avl_sop)
         && $stable(avl_eop) && $stable(avl_error) && $stable(avl_empty));

endmodule

//--- logic/ilk_rx_stats.sv
`timescale 1ns/1ps

module ilk_rx_stats (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  beat_valid,
   input  logic                  beat_ready,
   input  logic                  beat_sop,
   input  logic                  beat_eop,
   input  logic                  beat_error,
   input  logic                  drop,        // one pulse per lost beat
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  ilk_rx_pkg::apb_addr_t paddr,
   input  ilk_rx_pkg::apb_data_t pwdata,
   output ilk_rx_pkg::apb_data_t prdata,
   output logic                  pready,
   output logic                  pslverr
);

   import ilk_rx_pkg::*;

   logic beat_fire;
   logic pkt_open;    // sop seen and eop not yet
   logic frame_err;
   logic access;
   logic addr_hit;
   logic clear;
   cnt_t pkt_cnt;
   cnt_t err_cnt;
   cnt_t drop_cnt;
   cnt_t frame_cnt;

   // counters stick at all ones
   function automatic cnt_t sat_inc(input cnt_t cnt, input logic inc);
      if (inc && (cnt != '1)) begin
         return cnt + 1'b1;
      end
      return cnt;
   endfunction

   assign beat_fire = beat_valid && beat_ready;
   assign frame_err = beat_fire && (beat_sop == pkt_open);  // double sop or missing sop

   assign access = psel && penable;
   assign clear  = access && pwrite && (paddr == REG_CTRL) && pwdata[0];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pkt_open  <= 1'b0;
         pkt_cnt   <= '0;
         err_cnt   <= '0;
         drop_cnt  <= '0;
         frame_cnt <= '0;
      end else begin
         if (beat_fire) begin
            pkt_open <= !beat_eop;
         end
         if (clear) begin
            pkt_cnt   <= '0;
            err_cnt   <= '0;
            drop_cnt  <= '0;
            frame_cnt <= '0;
         end else begin
            pkt_cnt   <= sat_inc(pkt_cnt, beat_fire && beat_eop);
            err_cnt   <= sat_inc(err_cnt, beat_fire && beat_eop && beat_error);
            drop_cnt  <= sat_inc(drop_cnt, drop);
            frame_cnt <= sat_inc(frame_cnt, frame_err);
         end
      end
   end

   always_comb begin
      addr_hit = 1'b1;
      prdata   = '0;
      case (paddr)
         REG_PKT:   prdata = apb_data_t'(pkt_cnt);
         REG_ERR:   prdata = apb_data_t'(err_cnt);
         REG_DROP:  prdata = apb_data_t'(drop_cnt);
         REG_FRAME: prdata = apb_data_t'(frame_cnt);
         REG_CTRL:  prdata = '0;  // clear bit is self-clearing
         default:   addr_hit = 1'b0;
      endcase
   end

   assign pready  = 1'b1;  // no wait states
   assign pslverr = access && (!addr_hit || (pwrite && (paddr != REG_CTRL)));

   assert property (@(posedge clk) disable iff (!rst_n)
      pslverr |-> psel && penable);

endmodule

//--- logic/ilk_rx_top.sv
`timescale 1ns/1ps

module ilk_rx_top (
   input  logic                   clk,
   input  logic                   rst_n,
   // interlaken receive segments
   input  logic                   ilk_valid,
   input  ilk_rx_pkg::seg_data_t  ilk_data,
   input  ilk_rx_pkg::num_valid_t ilk_num_valid,
   input  logic                   ilk_sop,
   input  ilk_rx_pkg::eopbits_t   ilk_eopbits,
   // avalon-st source
   output ilk_rx_pkg::seg_data_t  avl_data,
   output logic                   avl_sop,
   output logic                   avl_eop,
   output ilk_rx_pkg::empty_t     avl_empty,
   output logic                   avl_error,
   output logic                   avl_valid,
   input  logic                   avl_ready,
   // apb status port
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  ilk_rx_pkg::apb_addr_t  paddr,
   input  ilk_rx_pkg::apb_data_t  pwdata,
   output ilk_rx_pkg::apb_data_t  prdata,
   output logic                   pready,
   output logic                   pslverr
);

   logic drop;  // buffer overflow pulse

   avl_beat_if beat_if ();

   ilk_to_avalon_adapter adapter_i (
      .ilk_valid     (ilk_valid),
      .ilk_data      (ilk_data),
      .ilk_num_valid (ilk_num_valid),
      .ilk_sop       (ilk_sop),
      .ilk_eopbits   (ilk_eopbits),
      .beat          (beat_if.source)
   );

   avl_out_fifo fifo_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .beat      (beat_if.sink),
      .avl_data  (avl_data),
      .avl_sop   (avl_sop),
      .avl_eop   (avl_eop),
      .avl_error (avl_error),
      .avl_empty (avl_empty),
      .avl_valid (avl_valid),
      .avl_ready (avl_ready),
      .drop      (drop)
   );

   // taps the outgoing beat
   ilk_rx_stats stats_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .beat_valid (avl_valid),
      .beat_ready (avl_ready),
      .beat_sop   (avl_sop),
      .beat_eop   (avl_eop),
      .beat_error (avl_error),
      .drop       (drop),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr)
   );

endmodule

//--- sim/tb_ilk_rx.sv
`timescale 1ns/1ps

module tb_ilk_rx;

   import ilk_rx_pkg::*;

   localparam int SEG_BUDGET  = 150;  // upper bound on segments driven below
   localparam int WATCHDOG_NS = (SEG_BUDGET + 200) * 20;

   typedef struct packed {
      seg_data_t data;
      logic      sop;
      logic      eop;
      logic      error;
      empty_t    empty;
   } beat_t;

   logic       clk;
   logic       rst_n;
   logic       ilk_valid;
   seg_data_t  ilk_data;
   num_valid_t ilk_num_valid;
   logic       ilk_sop;
   eopbits_t   ilk_eopbits;
   seg_data_t  avl_data;
   logic       avl_sop;
   logic       avl_eop;
   empty_t     avl_empty;
   logic       avl_error;
   logic       avl_valid;
   logic       avl_ready;
   logic       psel;
   logic       penable;
   logic       pwrite;
   apb_addr_t  paddr;
   apb_data_t  pwdata;
   apb_data_t  prdata;
   logic       pready;
   logic       pslverr;

   integer    seed = 32'h706f866a;
   int        errors = 0;
   int        beats_seen = 0;
   beat_t     exp_q[$];        // mirrors the DUT beat buffer
   beat_t     exp_beat;
   logic      exp_valid;
   logic      take;
   int        m_pkt, m_err, m_drop, m_frame;
   logic      m_open;
   apb_data_t exp_prdata;
   logic      exp_slverr;
   logic      check_rd;

   ilk_rx_top ilk_rx_top_i (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic note_mismatch(input string name, input string exp, input string act);
      errors++;
      $display("ERROR %0t %s expected %s actual %s", $time, name, exp, act);
   endtask

   // expected beat for the segment now on the inputs, 0 when no beat exists
   function automatic logic decode_segment(output beat_t b);
      int n;
      int base;
      b = '0;
      n = int'(ilk_num_valid);
      if (!ilk_valid || n < 1 || n > 4) begin
         return 1'b0;
      end
      base   = 8 * (4 - n);
      b.data = ilk_data;
      b.sop  = ilk_sop;
      b.eop  = 1'b1;
      if (ilk_eopbits == 4'b0000) begin
         b.eop   = 1'b0;
         b.empty = empty_t'(base);
      end else if (ilk_eopbits == 4'b1000) begin
         b.empty = empty_t'(base);
      end else if (ilk_eopbits[3]) begin
         b.empty = empty_t'(base + 8 - int'(ilk_eopbits[2:0]));
      end else begin
         b.error = 1'b1;  // 0001 and codes 0010 to 0111
      end
      return 1'b1;
   endfunction

   // runs mid-cycle when inputs and outputs are settled
   always @(negedge clk) begin : model
      logic  fire;
      beat_t nb;
      if (!rst_n) begin
         exp_q.delete();
         exp_valid = 1'b0;
      end else begin
         exp_valid = (exp_q.size() != 0);
         if (exp_valid) begin
            exp_beat = exp_q[0];
         end
         fire = exp_valid && avl_ready;
         if (fire) begin
            beats_seen++;
            if ((exp_beat.sop && m_open) || (!exp_beat.sop && !m_open)) begin
               m_frame++;
            end
            if (exp_beat.eop) begin
               m_pkt++;
               m_err += exp_beat.error ? 1 : 0;
            end
            m_open = !exp_beat.eop;
            void'(exp_q.pop_front());
         end
         if (decode_segment(nb)) begin
            if (exp_q.size() < FIFO_DEPTH) begin
               exp_q.push_back(nb);
            end else begin
               m_drop++;  // buffer full and nothing left this cycle
            end
         end
      end
   end

   assign take = avl_valid && avl_ready && exp_valid;

   assert property (@(posedge clk) disable iff (!rst_n) avl_valid == exp_valid)
      else note_mismatch("avl_valid", $sformatf("%0h", exp_valid),
                         $sformatf("%0h", $sampled(avl_valid)));
   assert property (@(posedge clk) disable iff (!rst_n) take |-> avl_data == exp_beat.data)
      else note_mismatch("avl_data", $sformatf("%0h", exp_beat.data),
                         $sformatf("%0h", $sampled(avl_data)));
   assert property (@(posedge clk) disable iff (!rst_n) take |-> avl_sop == exp_beat.sop)
      else note_mismatch("avl_sop", $sformatf("%0h", exp_beat.sop),
                         $sformatf("%0h", $sampled(avl_sop)));
   assert property (@(posedge clk) disable iff (!rst_n) take |-> avl_eop == exp_beat.eop)
      else note_mismatch("avl_eop", $sformatf("%0h", exp_beat.eop),
                         $sformatf("%0h", $sampled(avl_eop)));
   assert property (@(posedge clk) disable iff (!rst_n) take |-> avl_empty == exp_beat.empty)
      else note_mismatch("avl_empty", $sformatf("%0d", exp_beat.empty),
                         $sformatf("%0d", $sampled(avl_empty)));
   assert property (@(posedge clk) disable iff (!rst_n) take |-> avl_error == exp_beat.error)
      else note_mismatch("avl_error", $sformatf("%0h", exp_beat.error),
                         $sformatf("%0h", $sampled(avl_error)));
   assert property (@(posedge clk) disable iff (!rst_n)
      (psel && penable && check_rd) |-> prdata == exp_prdata)
      else note_mismatch($sformatf("prdata at %0h", paddr), $sformatf("%0h", exp_prdata),
                         $sformatf("%0h", $sampled(prdata)));
   assert property (@(posedge clk) disable iff (!rst_n) pslverr == (psel && penable && exp_slverr))
      else note_mismatch("pslverr", $sformatf("%0h", psel && penable && exp_slverr),
                         $sformatf("%0h", $sampled(pslverr)));
   assert property (@(posedge clk) disable iff (!rst_n) (psel && penable) |-> pready)
      else note_mismatch("pready", "1", "0");

   function automatic seg_data_t random_data();
      seg_data_t d;
      for (int i = 0; i < WORDS * 2; i++) begin
         d[i*32 +: 32] = $random(seed);
      end
      return d;
   endfunction

   task automatic send_segment(input logic valid, input num_valid_t n, input logic sop,
                               input eopbits_t code, input logic ready);
      @(posedge clk);
      #2;
      ilk_valid     = valid;
      ilk_num_valid = n;
      ilk_sop       = sop;
      ilk_eopbits   = code;
      ilk_data      = random_data();
      avl_ready     = ready;
   endtask

   task automatic idle_cycles(input int cycles);
      repeat (cycles) begin
         @(posedge clk);
         #2;
         ilk_valid = 1'b0;
      end
   endtask

   task automatic drain_buffer();
      idle_cycles(1);
      avl_ready = 1'b1;
      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
      idle_cycles(2);  // let the counters catch up
   endtask

   // setup phase then one access phase, no wait states
   task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                             input apb_data_t exp_rd, input logic exp_err);
      @(posedge clk);
      #2;
      psel       = 1'b1;
      penable    = 1'b0;
      pwrite     = wr;
      paddr      = addr;
      pwdata     = wdata;
      exp_prdata = exp_rd;
      exp_slverr = exp_err;
      check_rd   = !wr && !exp_err;
      @(posedge clk);
      #2;
      penable = 1'b1;
      @(posedge clk);
      #2;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      check_rd = 1'b0;
   endtask

   task automatic check_counters();
      apb_access(1'b0, REG_PKT, '0, apb_data_t'(m_pkt), 1'b0);
      apb_access(1'b0, REG_ERR, '0, apb_data_t'(m_err), 1'b0);
      apb_access(1'b0, REG_DROP, '0, apb_data_t'(m_drop), 1'b0);
      apb_access(1'b0, REG_FRAME, '0, apb_data_t'(m_frame), 1'b0);
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, the test did not finish", WATCHDOG_NS);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      rst_n = 1'b0;
      ilk_valid = 1'b0;
      ilk_data = '0;
      ilk_num_valid = '0;
      ilk_sop = 1'b0;
      ilk_eopbits = '0;
      avl_ready = 1'b1;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      exp_prdata = '0;
      exp_slverr = 1'b0;
      check_rd = 1'b0;
      m_pkt = 0;
      m_err = 0;
      m_drop = 0;
      m_frame = 0;
      m_open = 1'b0;
      repeat (3) @(posedge clk);
      #2;
      rst_n = 1'b1;
      check_counters();  // all zero out of reset
      for (int n = 1; n <= 4; n++) begin
         for (int c = 0; c < 16; c++) begin
            send_segment(1'b1, num_valid_t'(n), c[0], eopbits_t'(c), 1'b1);
         end
      end
      for (int n = 5; n <= 8; n++) begin
         send_segment(1'b1, num_valid_t'(n), 1'b1, 4'b1000, 1'b1);  // 8 wraps to 0
      end
      for (int n = 1; n <= 4; n++) begin
         send_segment(1'b0, num_valid_t'(n), 1'b1, 4'b1000, 1'b1);
      end
      repeat (60) begin
         send_segment(1'($random(seed)), num_valid_t'($random(seed)), 1'($random(seed)),
                      eopbits_t'($random(seed)), 1'($random(seed)));
      end
      drain_buffer();
      check_counters();
      apb_access(1'b1, REG_CTRL, 32'h1, '0, 1'b0);
      m_pkt = 0;
      m_err = 0;
      m_drop = 0;
      m_frame = 0;
      check_counters();
      // stalled sink, the last two beats overflow
      for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
         send_segment(1'b1, 3'd4, 1'b1, 4'b1000, 1'b0);
      end
      idle_cycles(2);
      check_counters();
      drain_buffer();
      send_segment(1'b1, 3'd4, 1'b1, 4'b0000, 1'b1);
      send_segment(1'b1, 3'd4, 1'b1, 4'b1000, 1'b1);  // sop inside an open packet
      send_segment(1'b1, 3'd4, 1'b0, 4'b1000, 1'b1);  // no sop
      send_segment(1'b1, 3'd2, 1'b0, 4'b0011, 1'b1);
      drain_buffer();
      check_counters();
      apb_access(1'b0, 8'h14, '0, '0, 1'b1);
      apb_access(1'b1, REG_PKT, 32'h5, '0, 1'b1);
      apb_access(1'b1, REG_FRAME, 32'h1, '0, 1'b1);
      apb_access(1'b0, REG_CTRL, '0, '0, 1'b0);
      check_counters();  // rejected writes leave the counts alone
      if (exp_q.size() != 0 || beats_seen == 0) begin
         errors++;
         $display("expected beats were left over or no beat was ever checked");
      end
      $display("%0d beats checked, %0d errors", beats_seen, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- flist.f
logic/ilk_rx_pkg.sv
logic/avl_beat_if.sv
logic/ilk_to_avalon_adapter.sv
logic/avl_out_fifo.sv
logic/ilk_rx_stats.sv
logic/ilk_rx_top.sv
sim/tb_ilk_rx.sv

//--- Makefile
# Verilator flow for the Interlaken receive bridge
VERILATOR ?= verilator
TOP       ?= tb_ilk_rx
FLIST     ?= flist.f
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

PASS_MSG = Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
